// File: design/fs_bus_pkg.sv
`default_nettype none

package fs_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 16;

    typedef logic [DATA_W-1:0] fs_data_t;

    // Full APB request as driven by the master.
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        fs_data_t          pwdata;
    } apb_req_t;

    // Register map, word addresses.
    localparam logic [ADDR_W-1:0] ADDR_GRL_FLAGS   = 32'h0000_0040;
    localparam logic [ADDR_W-1:0] ADDR_OVUV_REACT1 = 32'h0000_0041;
    localparam logic [ADDR_W-1:0] ADDR_OVUV_REACT2 = 32'h0000_0043;
    localparam logic [ADDR_W-1:0] ADDR_WD_CFG      = 32'h0000_0045;
    localparam logic [ADDR_W-1:0] ADDR_WD_WINDOW   = 32'h0000_004D;
    localparam logic [ADDR_W-1:0] ADDR_WD_SEED     = 32'h0000_004F;
    localparam logic [ADDR_W-1:0] ADDR_WD_ANSWER   = 32'h0000_0050;
    localparam logic [ADDR_W-1:0] ADDR_OVUV_STATUS = 32'h0000_0051;

    // One select per mapped register.
    typedef enum logic [3:0] {
        REG_NONE,
        REG_GRL_FLAGS,
        REG_OVUV_REACT1,
        REG_OVUV_REACT2,
        REG_WD_CFG,
        REG_WD_WINDOW,
        REG_WD_SEED,
        REG_WD_ANSWER,
        REG_OVUV_STATUS
    } fs_reg_e;

endpackage

`default_nettype wire

// File: design/fs_field_pkg.sv
`default_nettype none

package fs_field_pkg;

    import fs_bus_pkg::*;

    localparam int WD_ERR_CNT_W = 4;

    typedef logic [1:0] fs_impact_t; // Safety impact code.

    typedef struct packed {
        fs_impact_t vcoremon_ov_impact;
        fs_impact_t vcoremon_uv_impact;
        logic       rsvd_11;
        logic       vcoremon_abist2;
        logic       vddio_abist2;
        logic       vmon1_abist2;
        logic       vmon2_abist2;
        logic       vmon3_abist2;
        logic       vmon4_abist2;
        logic       rsvd_4;
        fs_impact_t vddio_ov_impact;
        fs_impact_t vddio_uv_impact;
    } ovuv_react1_t;

    typedef struct packed {
        fs_impact_t vmon4_ov_impact;
        fs_impact_t vmon4_uv_impact;
        fs_impact_t vmon3_ov_impact;
        fs_impact_t vmon3_uv_impact;
        fs_impact_t vmon2_ov_impact;
        fs_impact_t vmon2_uv_impact;
        fs_impact_t vmon1_ov_impact;
        fs_impact_t vmon1_uv_impact;
    } ovuv_react2_t;

    typedef struct packed {
        logic vcoremon_ov;
        logic vcoremon_uv;
        logic vddio_ov;
        logic vddio_uv;
        logic vmon4_ov;
        logic vmon4_uv;
        logic vmon3_ov;
        logic vmon3_uv;
        logic vmon2_ov;
        logic vmon2_uv;
        logic vmon1_ov;
        logic vmon1_uv;
        logic rsvd_3;
        logic dig_ref_ov;
        logic osc_drift;
        logic rsvd_0;
    } ovuv_status_t;

    typedef struct packed {
        logic [1:0]              err_limit;
        logic [1:0]              rsvd_13_12;
        logic [1:0]              rfr_limit;
        fs_impact_t              fs_impact;
        logic                    rsvd_7;
        logic [2:0]              rfr_cnt;
        logic [WD_ERR_CNT_W-1:0] err_cnt; // Read-only, from the watchdog.
    } wd_cfg_t;

    typedef struct packed {
        logic [4:0] period;
        logic [2:0] dc;
        logic [3:0] rsvd_7_4;
        logic [3:0] recovery;
    } wd_window_t;

    typedef struct packed {
        logic        com;
        logic        wd;
        logic        io;
        logic        reg_ovuv;
        logic [11:0] rsvd_11_0;
    } grl_flags_t;

    localparam fs_data_t RST_OVUV_REACT1 = 16'hC00C;
    localparam fs_data_t RST_OVUV_REACT2 = 16'hDDDD;
    localparam fs_data_t RST_WD_CFG      = 16'h4200; // err_cnt bits zero.
    localparam fs_data_t RST_WD_WINDOW   = 16'h1A0B;
    localparam fs_data_t RST_WD_SEED     = 16'h5AB2;
    localparam fs_data_t RST_WD_ANSWER   = 16'h0000;
    localparam fs_data_t RST_OVUV_STATUS = 16'h0000;

    // Writable bits; seed and answer take the whole word.
    localparam fs_data_t WMASK_OVUV_REACT1 = 16'hF7EF;
    localparam fs_data_t WMASK_OVUV_REACT2 = 16'hFFFF;
    localparam fs_data_t WMASK_WD_CFG      = 16'hCF70;
    localparam fs_data_t WMASK_WD_WINDOW   = 16'hFF0F;
    localparam fs_data_t WMASK_OVUV_STATUS = 16'hFFF6;

endpackage

`default_nettype wire

// File: design/fs_apb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fs_apb_decode (
    input  fs_bus_pkg::apb_req_t apb,
    output fs_bus_pkg::fs_reg_e  sel,
    output logic                 wr_en
);

    import fs_bus_pkg::*;

    // Access phase of a write; no wait states.
    assign wr_en = apb.psel & apb.pwrite & apb.penable;

    // Full address compare, anything else is unmapped.
    always_comb begin
        case (apb.paddr)
            ADDR_GRL_FLAGS: begin
                sel = REG_GRL_FLAGS;
            end
            ADDR_OVUV_REACT1: begin
                sel = REG_OVUV_REACT1;
            end
            ADDR_OVUV_REACT2: begin
                sel = REG_OVUV_REACT2;
            end
            ADDR_WD_CFG: begin
                sel = REG_WD_CFG;
            end
            ADDR_WD_WINDOW: begin
                sel = REG_WD_WINDOW;
            end
            ADDR_WD_SEED: begin
                sel = REG_WD_SEED;
            end
            ADDR_WD_ANSWER: begin
                sel = REG_WD_ANSWER;
            end
            ADDR_OVUV_STATUS: begin
                sel = REG_OVUV_STATUS;
            end
            default: begin
                sel = REG_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/fs_ovuv_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fs_ovuv_cfg_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  fs_bus_pkg::fs_reg_e        sel,
    input  logic                       wr_en,
    input  fs_bus_pkg::fs_data_t       wdata,
    output fs_field_pkg::ovuv_react1_t react1,
    output fs_field_pkg::ovuv_react2_t react2,
    output fs_field_pkg::ovuv_status_t status
);

    import fs_bus_pkg::*;
    import fs_field_pkg::*;

    logic wr_react1;
    logic wr_react2;
    logic wr_status;

    assign wr_react1 = wr_en && (sel == REG_OVUV_REACT1);
    assign wr_react2 = wr_en && (sel == REG_OVUV_REACT2);
    assign wr_status = wr_en && (sel == REG_OVUV_STATUS);

    // Reserved bits drop out under the mask.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            react1 <= ovuv_react1_t'(RST_OVUV_REACT1);
        end else if (wr_react1) begin
            react1 <= ovuv_react1_t'(wdata & WMASK_OVUV_REACT1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            react2 <= ovuv_react2_t'(RST_OVUV_REACT2);
        end else if (wr_react2) begin
            react2 <= ovuv_react2_t'(wdata & WMASK_OVUV_REACT2);
        end
    end

    // Status flags are set and cleared by software.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= ovuv_status_t'(RST_OVUV_STATUS);
        end else if (wr_status) begin
            status <= ovuv_status_t'(wdata & WMASK_OVUV_STATUS);
        end
    end

endmodule

`default_nettype wire

// File: design/fs_wd_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fs_wd_cfg_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fs_bus_pkg::fs_reg_e      sel,
    input  logic                     wr_en,
    input  fs_bus_pkg::fs_data_t     wdata,
    output fs_field_pkg::wd_cfg_t    wd_cfg,
    output fs_field_pkg::wd_window_t wd_window,
    output fs_bus_pkg::fs_data_t     wd_seed,
    output fs_bus_pkg::fs_data_t     wd_answer
);

    import fs_bus_pkg::*;
    import fs_field_pkg::*;

    fs_data_t                           cfg_wdata;
    logic [DATA_W-1:WD_ERR_CNT_W]       cfg_q; // Upper bits only.

    assign cfg_wdata = wdata & WMASK_WD_CFG;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= RST_WD_CFG[DATA_W-1:WD_ERR_CNT_W];
        end else if (wr_en && (sel == REG_WD_CFG)) begin
            cfg_q <= cfg_wdata[DATA_W-1:WD_ERR_CNT_W];
        end
    end

    // Error count is filled in on the read path.
    assign wd_cfg = wd_cfg_t'({cfg_q, {WD_ERR_CNT_W{1'b0}}});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wd_window <= wd_window_t'(RST_WD_WINDOW);
        end else if (wr_en && (sel == REG_WD_WINDOW)) begin
            wd_window <= wd_window_t'(wdata & WMASK_WD_WINDOW);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wd_seed   <= RST_WD_SEED;
            wd_answer <= RST_WD_ANSWER;
        end else begin
            if (wr_en && (sel == REG_WD_SEED)) begin
                wd_seed <= wdata;
            end
            if (wr_en && (sel == REG_WD_ANSWER)) begin
                wd_answer <= wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fs_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module fs_read_mux (
    input  fs_bus_pkg::fs_reg_e                   sel,
    input  fs_field_pkg::ovuv_react1_t            react1,
    input  fs_field_pkg::ovuv_react2_t            react2,
    input  fs_field_pkg::ovuv_status_t            status,
    input  fs_field_pkg::wd_cfg_t                 wd_cfg,
    input  fs_field_pkg::wd_window_t              wd_window,
    input  fs_bus_pkg::fs_data_t                  wd_seed,
    input  fs_bus_pkg::fs_data_t                  wd_answer,
    input  logic [fs_field_pkg::WD_ERR_CNT_W-1:0] wd_err_cnt,
    input  fs_field_pkg::grl_flags_t              grl_flags,
    output fs_bus_pkg::fs_data_t                  prdata
);

    import fs_bus_pkg::*;
    import fs_field_pkg::*;

    wd_cfg_t    wd_cfg_img;
    grl_flags_t grl_img;

    always_comb begin
        wd_cfg_img         = wd_cfg;
        wd_cfg_img.err_cnt = wd_err_cnt; // Live count from the watchdog.
    end

    // Only the four group flags show; the low bits read zero.
    always_comb begin
        grl_img          = '0;
        grl_img.com      = grl_flags.com;
        grl_img.wd       = grl_flags.wd;
        grl_img.io       = grl_flags.io;
        grl_img.reg_ovuv = grl_flags.reg_ovuv;
    end

    always_comb begin
        case (sel)
            REG_GRL_FLAGS:   prdata = fs_data_t'(grl_img);
            REG_OVUV_REACT1: prdata = fs_data_t'(react1);
            REG_OVUV_REACT2: prdata = fs_data_t'(react2);
            REG_WD_CFG:      prdata = fs_data_t'(wd_cfg_img);
            REG_WD_WINDOW:   prdata = fs_data_t'(wd_window);
            REG_WD_SEED:     prdata = wd_seed;
            REG_WD_ANSWER:   prdata = wd_answer;
            REG_OVUV_STATUS: prdata = fs_data_t'(status);
            default:         prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/fs_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module fs_cfg_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  fs_bus_pkg::apb_req_t                  apb,
    output fs_bus_pkg::fs_data_t                  prdata,
    input  fs_field_pkg::grl_flags_t              grl_flags,
    input  logic [fs_field_pkg::WD_ERR_CNT_W-1:0] wd_err_cnt,
    output fs_field_pkg::ovuv_react1_t            react1,
    output fs_field_pkg::ovuv_react2_t            react2,
    output fs_field_pkg::ovuv_status_t            status,
    output fs_field_pkg::wd_cfg_t                 wd_cfg,
    output fs_field_pkg::wd_window_t              wd_window,
    output fs_bus_pkg::fs_data_t                  wd_seed,
    output fs_bus_pkg::fs_data_t                  wd_answer
);

    import fs_bus_pkg::*;

    fs_reg_e sel;
    logic    wr_en;

    fs_apb_decode u_decode (
        .apb   (apb),
        .sel   (sel),
        .wr_en (wr_en)
    );

    fs_ovuv_cfg_regs u_ovuv_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .sel    (sel),
        .wr_en  (wr_en),
        .wdata  (apb.pwdata),
        .react1 (react1),
        .react2 (react2),
        .status (status)
    );

    fs_wd_cfg_regs u_wd_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (sel),
        .wr_en     (wr_en),
        .wdata     (apb.pwdata),
        .wd_cfg    (wd_cfg),
        .wd_window (wd_window),
        .wd_seed   (wd_seed),
        .wd_answer (wd_answer)
    );

    // Read data follows paddr, psel not required.
    fs_read_mux u_read_mux (
        .sel        (sel),
        .react1     (react1),
        .react2     (react2),
        .status     (status),
        .wd_cfg     (wd_cfg),
        .wd_window  (wd_window),
        .wd_seed    (wd_seed),
        .wd_answer  (wd_answer),
        .wd_err_cnt (wd_err_cnt),
        .grl_flags  (grl_flags),
        .prdata     (prdata)
    );

endmodule

`default_nettype wire

// File: verification/fs_cfg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fs_cfg_tb;

    import fs_bus_pkg::*;
    import fs_field_pkg::*;

    localparam int N_RAND_WR = 120;
    localparam int N_IGNORED = 20;
    // About 10 cycles per random write, 40 per ignored-access round, doubled.
    localparam int MAX_CYCLES = 2 * (N_RAND_WR * 10 + N_IGNORED * 40 + 50);

    logic                    clk;
    logic                    rst_n;
    apb_req_t                apb_req;
    fs_data_t                prdata;
    grl_flags_t              grl_flags;
    logic [WD_ERR_CNT_W-1:0] wd_err_cnt;
    ovuv_react1_t            react1;
    ovuv_react2_t            react2;
    ovuv_status_t            status;
    wd_cfg_t                 wd_cfg;
    wd_window_t              wd_window;
    fs_data_t                wd_seed;
    fs_data_t                wd_answer;

    fs_data_t    model [16]; // Indexed by register select.
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          check_count;

    fs_cfg_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb        (apb_req),
        .prdata     (prdata),
        .grl_flags  (grl_flags),
        .wd_err_cnt (wd_err_cnt),
        .react1     (react1),
        .react2     (react2),
        .status     (status),
        .wd_cfg     (wd_cfg),
        .wd_window  (wd_window),
        .wd_seed    (wd_seed),
        .wd_answer  (wd_answer)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the test did not complete", cycle_count);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation timeout");
        end
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] addr_of(input fs_reg_e r);
        case (r)
            REG_GRL_FLAGS:   return ADDR_GRL_FLAGS;
            REG_OVUV_REACT1: return ADDR_OVUV_REACT1;
            REG_OVUV_REACT2: return ADDR_OVUV_REACT2;
            REG_WD_CFG:      return ADDR_WD_CFG;
            REG_WD_WINDOW:   return ADDR_WD_WINDOW;
            REG_WD_SEED:     return ADDR_WD_SEED;
            REG_WD_ANSWER:   return ADDR_WD_ANSWER;
            REG_OVUV_STATUS: return ADDR_OVUV_STATUS;
            default:         return 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic fs_data_t mask_of(input fs_reg_e r);
        case (r)
            REG_OVUV_REACT1: return WMASK_OVUV_REACT1;
            REG_OVUV_REACT2: return WMASK_OVUV_REACT2;
            REG_WD_CFG:      return WMASK_WD_CFG;
            REG_WD_WINDOW:   return WMASK_WD_WINDOW;
            REG_WD_SEED:     return 16'hFFFF;
            REG_WD_ANSWER:   return 16'hFFFF;
            REG_OVUV_STATUS: return WMASK_OVUV_STATUS;
            default:         return 16'h0000; // Flags are read-only.
        endcase
    endfunction

    function automatic logic is_mapped(input logic [31:0] addr);
        for (int i = 1; i <= 8; i++) begin
            if (addr == addr_of(fs_reg_e'(i[3:0]))) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic fs_data_t expected_read(input fs_reg_e r);
        case (r)
            REG_GRL_FLAGS: begin
                return {grl_flags.com, grl_flags.wd, grl_flags.io, grl_flags.reg_ovuv, 12'h000};
            end
            REG_WD_CFG: begin
                return model[r] | {12'h000, wd_err_cnt};
            end
            default: begin
                return model[r];
            end
        endcase
    endfunction

    task automatic reset_model();
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        model[REG_OVUV_REACT1] = RST_OVUV_REACT1;
        model[REG_OVUV_REACT2] = RST_OVUV_REACT2;
        model[REG_WD_CFG]      = RST_WD_CFG;
        model[REG_WD_WINDOW]   = RST_WD_WINDOW;
        model[REG_WD_SEED]     = RST_WD_SEED;
        model[REG_WD_ANSWER]   = RST_WD_ANSWER;
        model[REG_OVUV_STATUS] = RST_OVUV_STATUS;
    endtask

    task automatic model_write(input fs_reg_e r, input fs_data_t data);
        fs_data_t mask;
        mask = mask_of(r);
        model[r] = (model[r] & ~mask) | (data & mask);
    endtask

    task automatic check_value(input string name, input fs_data_t expected,
                               input fs_data_t actual);
        check_count++;
        assert (actual === expected) else begin
            $display("mismatch %s expected 0x%04h actual 0x%04h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "register check failed");
        end
    endtask

    task automatic set_bus_idle();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input fs_data_t data);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.pwrite  = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1; // Access phase, written at next edge.
        @(posedge clk);
        #1;
        set_bus_idle();
    endtask

    task automatic setup_only(input logic [31:0] addr, input fs_data_t data);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.pwrite  = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        set_bus_idle();
    endtask

    task automatic bus_read(input logic [31:0] addr, output fs_data_t data);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.pwrite  = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.paddr   = addr;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        #1;
        set_bus_idle();
    endtask

    task automatic read_and_check(input string name, input fs_reg_e r);
        fs_data_t data;
        bus_read(addr_of(r), data);
        check_value({name, " ", r.name()}, expected_read(r), data);
    endtask

    task automatic read_all(input string name);
        for (int i = 1; i <= 8; i++) begin
            read_and_check(name, fs_reg_e'(i[3:0]));
        end
    endtask

    task automatic check_outputs(input string name);
        @(negedge clk);
        check_value({name, " react1 out"}, model[REG_OVUV_REACT1], fs_data_t'(react1));
        check_value({name, " react2 out"}, model[REG_OVUV_REACT2], fs_data_t'(react2));
        check_value({name, " status out"}, model[REG_OVUV_STATUS], fs_data_t'(status));
        check_value({name, " wd_cfg out"}, model[REG_WD_CFG], fs_data_t'(wd_cfg));
        check_value({name, " wd_window out"}, model[REG_WD_WINDOW], fs_data_t'(wd_window));
        check_value({name, " wd_seed out"}, model[REG_WD_SEED], wd_seed);
        check_value({name, " wd_answer out"}, model[REG_WD_ANSWER], wd_answer);
    endtask

    task automatic randomize_ro_inputs();
        logic [31:0] rnd;
        @(posedge clk);
        #1;
        draw_bits(4, rnd);
        wd_err_cnt = rnd[3:0];
        draw_bits(16, rnd);
        grl_flags = grl_flags_t'(rnd[15:0]); // Low bits must still read zero.
    endtask

    task automatic random_writes();
        logic [31:0] rnd;
        fs_reg_e     r;
        fs_data_t    data;
        for (int n = 0; n < N_RAND_WR; n++) begin
            randomize_ro_inputs();
            draw_bits(3, rnd);
            r = fs_reg_e'({1'b0, rnd[2:0]} + 4'd1); // Flags register included.
            draw_bits(16, rnd);
            data = rnd[15:0];
            bus_write(addr_of(r), data);
            model_write(r, data);
            check_outputs("random write");
            read_and_check("random write", r);
        end
    endtask

    task automatic ignored_accesses();
        logic [31:0] rnd;
        logic [31:0] addr;
        fs_data_t    data;
        fs_reg_e     r;
        for (int n = 0; n < N_IGNORED; n++) begin
            randomize_ro_inputs();
            draw_bits(32, rnd);
            if (n % 2 == 0) begin
                addr = {24'h0, 3'b010, rnd[4:0]}; // Gaps around the map.
            end else begin
                addr = rnd;
            end
            if (is_mapped(addr)) begin
                addr = addr ^ 32'h0000_1000;
            end
            bus_read(addr, data);
            check_value("unmapped read", 16'h0000, data);
            draw_bits(16, rnd);
            bus_write(addr, rnd[15:0]);
            draw_bits(3, rnd);
            r = fs_reg_e'({1'b0, rnd[2:0]} + 4'd1);
            draw_bits(16, rnd);
            setup_only(addr_of(r), ~model[r] ^ rnd[15:0]);
            check_outputs("ignored access");
            read_all("ignored access");
        end
    endtask

    initial begin
        lfsr_state  = 32'd93110;
        cycle_count = 0;
        check_count = 0;
        rst_n       = 1'b0;
        apb_req     = '0;
        grl_flags   = '0;
        wd_err_cnt  = '0;
        reset_model();

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        randomize_ro_inputs();
        check_outputs("reset");
        read_all("reset");

        random_writes();
        ignored_accesses();

        $display("%0d checks done", check_count);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
design/fs_bus_pkg.sv
design/fs_field_pkg.sv
design/fs_apb_decode.sv
design/fs_ovuv_cfg_regs.sv
design/fs_wd_cfg_regs.sv
design/fs_read_mux.sv
design/fs_cfg_top.sv
verification/fs_cfg_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing -j 0
TOP       := fs_cfg_tb
RTL_TOP   := fs_cfg_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
